//--- vlog.f
adc_pkg.sv
adc_clk_div.sv
trigger_sequencer.sv
sample_averager.sv
adc_apb_regs.sv
adc_sampler_top.sv
tb_adc_sampler.sv

//--- run.sh
#!/bin/sh
# build and run the acquisition controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	--top-module tb_adc_sampler \
	-f vlog.f -o sim_adc_sampler
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/sim_adc_sampler
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit 1
fi
exit 0

//--- tb_adc_sampler.sv
// acquisition controller testbench
`timescale 1ns/1ps

module tb_adc_sampler
	import adc_pkg::*;
();

	localparam int NUM_RUNS  = 3;
	localparam int NUM_WORDS = NUM_PHASES * NUM_REPS;
	localparam int RUN_LIMIT = 5000;               // clk cycles allowed for one run
	localparam logic [31:0] SEED = 32'h58f2ce42;

	logic                  clk;
	logic                  rst;
	logic                  psel;
	logic                  penable;
	logic                  pwrite;
	logic [APB_ADDR_W-1:0] paddr;
	logic [APB_DATA_W-1:0] pwdata;
	logic [APB_DATA_W-1:0] prdata;
	logic                  pready;
	logic                  pslverr;
	logic [SAMPLE_W-1:0]   bn;
	logic                  adc_clk;
	logic [NUM_CH-1:0]     trigger_vdd;
	logic [NUM_CH-1:0]     trigger_gnd;
	logic                  end_flag;

	// one row per run: select, restart attempt, bn words, expected means
	logic [SEL_W-1:0]    run_sel     [NUM_RUNS] = '{3'd2, 3'd0, 3'd6};
	logic                run_restart [NUM_RUNS] = '{1'b0, 1'b1, 1'b0};
	logic [SAMPLE_W-1:0] run_bn      [NUM_RUNS][NUM_WORDS];
	logic [MEAN_W-1:0]   run_mean    [NUM_RUNS][NUM_PHASES];

	logic              watch;                      // trigger monitor enabled
	logic [NUM_CH-1:0] exp_mask;
	logic [NUM_CH-1:0] vdd_prev;
	logic [NUM_CH-1:0] gnd_prev;
	int                vdd_len;
	int                gnd_len;
	int                pulse_cnt;
	int                run_idx;

	adc_sampler_top i_dut (
		.clk(clk), .rst(rst),
		.psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr),
		.bn(bn), .adc_clk(adc_clk),
		.trigger_vdd(trigger_vdd), .trigger_gnd(trigger_gnd),
		.end_flag(end_flag)
	);

	always #4 clk = ~clk;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("*** FAILED ***");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			abort_run($sformatf("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp));
		end
	endtask

	// fibonacci lfsr, taps 32 22 2 1, new bit enters at bit 0
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// no channel selected means no pulses, so bn holds the first word
	function automatic logic [NUM_CH-1:0] sel_mask(input logic [SEL_W-1:0] s);
		if (s < 3'd4) begin
			return 4'b0001 << s;
		end
		return 4'b0000;
	endfunction

	task automatic build_table();
		logic [31:0]         s;
		logic [SAMPLE_W-1:0] w;
		logic [17:0]         sum;
		s = SEED;
		for (int r = 0; r < NUM_RUNS; r++) begin
			for (int k = 0; k < NUM_WORDS; k++) begin
				w = '0;
				for (int b = 0; b < SAMPLE_W; b++) begin
					s = lfsr_next(s);
					w = {w[SAMPLE_W-2:0], s[0]};
				end
				run_bn[r][k] = w;
			end
			for (int p = 0; p < NUM_PHASES; p++) begin
				sum = '0;
				for (int j = 0; j < NUM_REPS; j++) begin
					if (sel_mask(run_sel[r]) != '0) begin
						sum = sum + 18'(run_bn[r][NUM_REPS * p + j]);
					end else begin
						sum = sum + 18'(run_bn[r][0]);
					end
				end
				run_mean[r][p] = 16'(sum >> 2);
			end
		end
	endtask

	// setup phase, then access phase sampled at the falling edge
	task automatic bus_transfer(input logic wr, input logic [APB_ADDR_W-1:0] addr,
			input logic [31:0] data, output logic [31:0] rdata, output logic err);
		@(posedge clk);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= wr;
		paddr   <= addr;
		pwdata  <= data;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		check("pready", 32'(pready), 32'd1);
		rdata = prdata;
		err   = pslverr;
		@(posedge clk);
		psel    <= 1'b0;
		penable <= 1'b0;
		pwrite  <= 1'b0;
	endtask

	task automatic reg_write(input logic [APB_ADDR_W-1:0] addr, input logic [31:0] data,
			input logic exp_err);
		logic [31:0] rdata;
		logic        err;
		bus_transfer(1'b1, addr, data, rdata, err);
		check("pslverr", 32'(err), 32'(exp_err));
	endtask

	task automatic reg_read(input string name, input logic [APB_ADDR_W-1:0] addr,
			input logic [31:0] exp);
		logic [31:0] rdata;
		logic        err;
		bus_transfer(1'b0, addr, 32'd0, rdata, err);
		check("pslverr", 32'(err), 32'd0);
		check(name, rdata, exp);
	endtask

	task automatic check_adc_clk_period();
		int   n;
		int   high;
		logic prev;
		n    = 0;
		prev = adc_clk;
		while (1) begin
			@(negedge clk);
			if (adc_clk && !prev) break;
			prev = adc_clk;
			n++;
			if (n > 4 * CLK_DIV) abort_run("adc_clk never rose");
		end
		n    = 0;
		high = 1;
		prev = 1'b1;
		while (1) begin
			@(negedge clk);
			n++;
			if (adc_clk && !prev) break;
			if (adc_clk) high++;
			prev = adc_clk;
			if (n > 4 * CLK_DIV) abort_run("adc_clk stopped toggling");
		end
		check("adc_clk_period", 32'(n), 32'(CLK_DIV));
		check("adc_clk_high", 32'(high), 32'(CLK_DIV / 2));
	endtask

	task automatic wait_end_flag();
		int n;
		n = 0;
		while (1) begin
			@(negedge clk);
			if (end_flag === 1'b1) break;
			n++;
			if (n > RUN_LIMIT) abort_run("timeout waiting for end_flag after start");
		end
	endtask

	// trigger checks and bn feed, sampled at the falling edge
	always begin
		@(negedge clk);
		if (watch) begin
			check("trigger_overlap", 32'((|trigger_vdd) && (|trigger_gnd)), 32'd0);
			check("trigger_vdd", 32'(trigger_vdd & ~exp_mask), 32'd0);
			check("trigger_gnd", 32'(trigger_gnd & ~exp_mask), 32'd0);
			if (!(|trigger_vdd) && (|vdd_prev)) begin
				check("vdd_width", 32'(vdd_len), 32'(VDD_CYCLES));
				vdd_len = 0;
			end
			if (!(|trigger_gnd) && (|gnd_prev)) begin
				check("gnd_width", 32'(gnd_len), 32'(GND_CYCLES));
				gnd_len = 0;
			end
			if (|trigger_vdd) vdd_len++;
			if (|trigger_gnd) gnd_len++;
			vdd_prev = trigger_vdd;
			gnd_prev = trigger_gnd;
			if ((|trigger_vdd) && (vdd_len == 1)) begin  // pulse just started
				pulse_cnt++;
				@(posedge clk);
				if (pulse_cnt <= NUM_WORDS) bn <= run_bn[run_idx][pulse_cnt - 1];
			end
		end
	end

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		bn = '0;
		watch = 1'b0;
		exp_mask = '0;
		vdd_prev = '0;
		gnd_prev = '0;
		vdd_len = 0;
		gnd_len = 0;
		pulse_cnt = 0;
		run_idx = 0;
		build_table();
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		watch = 1'b1;

		// state after reset
		check("trigger_vdd", 32'(trigger_vdd), 32'd0);
		check("trigger_gnd", 32'(trigger_gnd), 32'd0);
		check("end_flag", 32'(end_flag), 32'd0);
		reg_read("status", ADDR_STATUS, 32'd0);
		for (int p = 0; p < NUM_PHASES; p++) begin
			reg_read($sformatf("mean%0d", p), 8'(ADDR_MEAN0 + 4 * p), 32'd0);
		end
		check_adc_clk_period();

		// register access and error responses
		reg_write(ADDR_CTRL, 32'h50, 1'b0);
		reg_read("ctrl_sel", ADDR_CTRL, 32'h50);
		reg_write(ADDR_CTRL, 32'h30, 1'b0);
		reg_read("ctrl_sel", ADDR_CTRL, 32'h30);
		reg_write(8'h40, 32'h1, 1'b1);
		reg_write(ADDR_MEAN0, 32'hffff, 1'b1);
		reg_write(ADDR_STATUS, 32'h3, 1'b1);
		reg_read("mean0", ADDR_MEAN0, 32'd0);
		begin : unmapped_read
			logic [31:0] rdata;
			logic        err;
			bus_transfer(1'b0, 8'h1c, 32'd0, rdata, err);
			check("pslverr", 32'(err), 32'd1);
		end

		for (int r = 0; r < NUM_RUNS; r++) begin
			run_idx   = r;
			pulse_cnt = 0;
			exp_mask  = sel_mask(run_sel[r]);
			@(posedge clk);
			bn <= run_bn[r][0];
			reg_write(ADDR_CTRL, 32'({run_sel[r], 4'b0001}), 1'b0);
			reg_read("status", ADDR_STATUS, 32'h1);  // busy, done cleared
			check("end_flag", 32'(end_flag), 32'd0);
			if (run_restart[r]) begin
				reg_write(ADDR_CTRL, 32'({run_sel[r], 4'b0001}), 1'b0);
			end
			wait_end_flag();
			check("pulse_count", 32'(pulse_cnt), (exp_mask != '0) ? 32'(NUM_WORDS) : 32'd0);
			reg_read("status", ADDR_STATUS, 32'h2);
			for (int p = 0; p < NUM_PHASES; p++) begin
				reg_read($sformatf("mean%0d", p), 8'(ADDR_MEAN0 + 4 * p), 32'(run_mean[r][p]));
			end
			check("end_flag", 32'(end_flag), 32'd1);  // still held after the reads
		end

		$display("*** PASSED ***");
		$finish;
	end

endmodule

//--- adc_sampler_top.sv
// acquisition controller top level
`timescale 1ns/1ps

module adc_sampler_top
	import adc_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  psel,
	input  logic                  penable,
	input  logic                  pwrite,
	input  logic [APB_ADDR_W-1:0] paddr,
	input  logic [APB_DATA_W-1:0] pwdata,
	output logic [APB_DATA_W-1:0] prdata,
	output logic                  pready,
	output logic                  pslverr,
	input  logic [SAMPLE_W-1:0]   bn,
	output logic                  adc_clk,
	output logic [NUM_CH-1:0]     trigger_vdd,
	output logic [NUM_CH-1:0]     trigger_gnd,
	output logic                  end_flag
);

	logic              tick;
	logic              start;
	logic [SEL_W-1:0]  sel;
	logic              busy;
	logic              done;
	logic              clear;
	logic              capture;
	phase_t            phase;
	logic [MEAN_W-1:0] mean [NUM_PHASES];

	adc_clk_div u_clk_div (
		.clk(clk), .rst(rst),
		.adc_clk(adc_clk), .tick(tick)
	);

	trigger_sequencer u_sequencer (
		.clk(clk), .rst(rst),
		.start(start), .sel(sel), .tick(tick),
		.trigger_vdd(trigger_vdd), .trigger_gnd(trigger_gnd),
		.busy(busy), .done(done),
		.clear(clear), .capture(capture), .phase(phase)
	);

	sample_averager u_averager (
		.clk(clk), .rst(rst),
		.clear(clear), .capture(capture), .phase(phase),
		.bn(bn), .mean(mean)
	);

	adc_apb_regs u_regs (
		.clk(clk), .rst(rst),
		.psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr),
		.busy(busy), .done(done), .mean(mean),
		.start(start), .sel(sel), .end_flag(end_flag)
	);

endmodule

//--- adc_apb_regs.sv
// apb control and status registers
`timescale 1ns/1ps

module adc_apb_regs
	import adc_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  psel,
	input  logic                  penable,
	input  logic                  pwrite,
	input  logic [APB_ADDR_W-1:0] paddr,
	input  logic [APB_DATA_W-1:0] pwdata,
	output logic [APB_DATA_W-1:0] prdata,
	output logic                  pready,
	output logic                  pslverr,
	input  logic                  busy,
	input  logic                  done,
	input  logic [MEAN_W-1:0]     mean [NUM_PHASES],
	output logic                  start,
	output logic [SEL_W-1:0]      sel,
	output logic                  end_flag
);

	logic                  access;    // apb access phase
	logic                  hit_ctrl;
	logic                  hit_status;
	logic                  hit_mean;
	logic [APB_DATA_W-1:0] mean_rdata;
	logic                  done_q;
	logic                  ctrl_wr;

	assign access     = psel && penable;
	assign hit_ctrl   = (paddr == ADDR_CTRL);
	assign hit_status = (paddr == ADDR_STATUS);
	assign ctrl_wr    = access && pwrite && hit_ctrl;

	always_comb begin
		hit_mean   = 1'b0;
		mean_rdata = '0;
		for (int i = 0; i < NUM_PHASES; i++) begin
			if (paddr == ADDR_MEAN0 + APB_ADDR_W'(4 * i)) begin
				hit_mean   = 1'b1;
				mean_rdata = APB_DATA_W'(mean[i]);
			end
		end
	end

	always_comb begin
		prdata = '0;
		if (hit_ctrl) begin
			prdata[CTRL_SEL_LSB +: SEL_W] = sel;     // start bit reads 0
		end else if (hit_status) begin
			prdata[STATUS_BUSY_BIT] = busy;
			prdata[STATUS_DONE_BIT] = done_q;
		end else if (hit_mean) begin
			prdata = mean_rdata;
		end
	end

	assign pready  = 1'b1;
	assign pslverr = access && (pwrite ? !hit_ctrl : !(hit_ctrl || hit_status || hit_mean));

	always_ff @(posedge clk) begin
		if (rst) begin
			sel   <= '0;
			start <= 1'b0;
		end else begin
			start <= ctrl_wr && pwdata[CTRL_START_BIT] && !busy; // ignored mid run
			if (ctrl_wr) begin
				sel <= pwdata[CTRL_SEL_LSB +: SEL_W];
			end
		end
	end

	// sticky done, cleared by the next start
	always_ff @(posedge clk) begin
		if (rst) begin
			done_q <= 1'b0;
		end else if (done) begin
			done_q <= 1'b1;
		end else if (start) begin
			done_q <= 1'b0;
		end
	end

	assign end_flag = done_q;

	a_penable_in_psel: assert property (@(posedge clk) disable iff (rst)
		penable |-> psel);

endmodule

//--- sample_averager.sv
// per phase sample averager
`timescale 1ns/1ps

module sample_averager
	import adc_pkg::*;
(
	input  logic                clk,
	input  logic                rst,
	input  logic                clear,
	input  logic                capture,
	input  phase_t              phase,
	input  logic [SAMPLE_W-1:0] bn,
	output logic [MEAN_W-1:0]   mean [NUM_PHASES]
);

	logic [MEAN_W-1:0] sum;       // running sum of the current phase
	logic [MEAN_W-1:0] sum_next;
	logic [REP_W-1:0]  cnt;
	logic              last;

	assign sum_next = sum + MEAN_W'(bn);
	assign last     = capture && (cnt == REP_W'(NUM_REPS - 1));

	always_ff @(posedge clk) begin
		if (rst) begin
			cnt <= '0;
		end else if (clear || last) begin
			cnt <= '0;
		end else if (capture) begin
			cnt <= cnt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (clear || last) begin
			sum <= '0;
		end else if (capture) begin
			sum <= sum_next;
		end
	end

	// four 14 bit words never overflow the 16 bit sum
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < NUM_PHASES; i++) begin
				mean[i] <= '0;
			end
		end else if (last) begin
			for (int i = 0; i < NUM_PHASES; i++) begin
				if (phase == phase_t'(i)) begin
					mean[i] <= sum_next >> MEAN_SHIFT;
				end
			end
		end
	end

endmodule

//--- trigger_sequencer.sv
// phase and trigger sequencer
`timescale 1ns/1ps

module trigger_sequencer
	import adc_pkg::*;
(
	input  logic              clk,
	input  logic              rst,
	input  logic              start,
	input  logic [SEL_W-1:0]  sel,
	input  logic              tick,
	output logic [NUM_CH-1:0] trigger_vdd,
	output logic [NUM_CH-1:0] trigger_gnd,
	output logic              busy,
	output logic              done,
	output logic              clear,
	output logic              capture,
	output phase_t            phase
);

	typedef enum logic [2:0] {
		S_IDLE,
		S_ALIGN,
		S_GROUND,
		S_DELAY,
		S_FIRE
	} state_t;

	state_t            state;
	logic [CNT_W-1:0]  step;      // cycles spent in the current step
	logic [REP_W-1:0]  rep;
	logic [SEL_W-1:0]  sel_q;     // channel held for the whole run
	logic [NUM_CH-1:0] ch_mask;
	logic              step_end;
	logic              last_rep;
	logic              last_phase;

	assign last_rep   = (rep == REP_W'(NUM_REPS - 1));
	assign last_phase = (phase == phase_t'(NUM_PHASES - 1));

	always_comb begin
		case (state)
			S_GROUND: step_end = (step == CNT_W'(GND_CYCLES - 1));
			S_DELAY:  step_end = (step == PHASE_DELAY[phase] - 1'b1);
			S_FIRE:   step_end = (step == CNT_W'(VDD_CYCLES - 1));
			default:  step_end = 1'b0;
		endcase
	end

	always_comb begin
		for (int i = 0; i < NUM_CH; i++) begin
			ch_mask[i] = (sel_q == SEL_W'(i)); // out of range select leaves mask empty
		end
	end

	assign trigger_gnd = (state == S_GROUND) ? ch_mask : '0;
	assign trigger_vdd = (state == S_FIRE) ? ch_mask : '0;
	assign busy        = (state != S_IDLE);
	assign clear       = start;
	assign capture     = (state == S_FIRE) && step_end; // last cycle of the pulse

	always_ff @(posedge clk) begin
		if (clear) begin
			sel_q <= sel;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= S_IDLE;
			step  <= '0;
			rep   <= '0;
			phase <= '0;
			done  <= 1'b0;
		end else begin
			done <= capture && last_rep && last_phase;
			case (state)
				S_IDLE: begin
					if (start) begin
						rep   <= '0;
						phase <= '0;
						state <= S_ALIGN;
					end
				end
				S_ALIGN: begin
					step <= '0;
					if (tick) begin
						state <= S_GROUND;
					end
				end
				S_GROUND: begin
					step <= step_end ? '0 : step + 1'b1;
					if (step_end) begin
						state <= S_DELAY;
					end
				end
				S_DELAY: begin
					step <= step_end ? '0 : step + 1'b1;
					if (step_end) begin
						state <= S_FIRE;
					end
				end
				S_FIRE: begin
					step <= step_end ? '0 : step + 1'b1;
					if (step_end) begin
						state <= S_ALIGN;
						rep   <= last_rep ? '0 : rep + 1'b1;
						if (last_rep && last_phase) begin
							state <= S_IDLE;            // run complete
						end else if (last_rep) begin
							phase <= phase + 1'b1;
						end
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// ground and supply never meet, not even back to back
	a_no_overlap: assert property (@(posedge clk) disable iff (rst)
		(|trigger_vdd) |-> !(|trigger_gnd) && !(|$past(trigger_gnd)));

	// capture closes a supply pulse of exactly full length
	a_capture_in_fire: assert property (@(posedge clk) disable iff (rst)
		capture |-> (state == S_FIRE) && ($past(state, VDD_CYCLES - 1) == S_FIRE)
			&& ($past(state, VDD_CYCLES) == S_DELAY));

endmodule

//--- adc_clk_div.sv
// converter clock divider
`timescale 1ns/1ps

module adc_clk_div
	import adc_pkg::*;
(
	input  logic clk,
	input  logic rst,
	output logic adc_clk,
	output logic tick
);

	localparam int HALF = CLK_DIV / 2;

	logic [4:0] cnt;    // position within one converter period
	logic       rise;
	logic       fall;

	assign rise = (cnt == 5'(HALF - 1));
	assign fall = (cnt == 5'(CLK_DIV - 1));

	always_ff @(posedge clk) begin
		if (rst) begin
			cnt <= '0;
		end else if (fall) begin
			cnt <= '0;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

	// tick rides along with the first high cycle of adc_clk
	always_ff @(posedge clk) begin
		if (rst) begin
			adc_clk <= 1'b0;
			tick    <= 1'b0;
		end else begin
			tick <= rise;
			if (rise) begin
				adc_clk <= 1'b1;
			end else if (fall) begin
				adc_clk <= 1'b0;
			end
		end
	end

endmodule

//--- adc_pkg.sv
// acquisition controller definitions
package adc_pkg;

	// converter and averaging
	localparam int SAMPLE_W   = 14;
	localparam int MEAN_W     = 16;
	localparam int NUM_PHASES = 5;
	localparam int NUM_REPS   = 4;
	localparam int REP_W      = $clog2(NUM_REPS);
	localparam int MEAN_SHIFT = $clog2(NUM_REPS);      // sum of four, divide by four

	// trigger channels
	localparam int NUM_CH = 4;
	localparam int SEL_W  = 3;                         // 4..7 selects nothing

	// timing in clk cycles
	localparam int CLK_DIV    = 20;                    // converter clock period
	localparam int GND_CYCLES = 20;
	localparam int VDD_CYCLES = 10;
	localparam int CNT_W      = 5;                     // step counter, holds up to 31

	localparam logic [CNT_W-1:0] PHASE_DELAY [NUM_PHASES] =
		'{5'd20, 5'd19, 5'd18, 5'd17, 5'd16};          // shrinks by one per phase

	// apb register map
	localparam int APB_ADDR_W = 8;
	localparam int APB_DATA_W = 32;

	localparam logic [APB_ADDR_W-1:0] ADDR_CTRL   = 8'h00;
	localparam logic [APB_ADDR_W-1:0] ADDR_STATUS = 8'h04;
	localparam logic [APB_ADDR_W-1:0] ADDR_MEAN0  = 8'h08; // five words up to 0x18

	localparam int CTRL_START_BIT  = 0;
	localparam int CTRL_SEL_LSB    = 4;
	localparam int STATUS_BUSY_BIT = 0;
	localparam int STATUS_DONE_BIT = 1;

	typedef logic [2:0] phase_t;

endpackage
